//--- include/conv_load_defines.svh
`ifndef CONV_LOAD_DEFINES_SVH
`define CONV_LOAD_DEFINES_SVH

//////////////////////////////
// bus and data widths
//////////////////////////////

`define CONV_APB_ADDR_W 8
// geometry values and loop indices
`define CONV_DIM_W 16
`define CONV_PIX_WORD_W 64

//////////////////////////////
// tiling and buffering
//////////////////////////////

// one bank per conv core column
`define CONV_BUFFERS_NUM 3
// channels per request, power of two
`define CONV_IF_GROUP 2
`define CONV_SEG_PIXELS 32

// words per bank
`define CONV_BUF_DEPTH 64
`define CONV_BUF_ADDR_W 6

`endif

//--- src/conv_load_pkg.sv
`include "conv_load_defines.svh"

package conv_load_pkg;

    //////////////////////////////
    // loop and geometry types
    //////////////////////////////

    // one-based row, column or channel index, or image size
    typedef logic [`CONV_DIM_W-1:0] dim_t;

    // conv stride, 1 to 3
    typedef logic [3:0] stride_t;

    //////////////////////////////
    // data and buffer types
    //////////////////////////////

    // one response beat
    typedef logic [`CONV_PIX_WORD_W-1:0] pix_word_t;

    // zero-based bank number
    typedef logic [$clog2(`CONV_BUFFERS_NUM)-1:0] bank_t;

    typedef logic [`CONV_BUF_ADDR_W-1:0] buf_addr_t;

endpackage

//--- src/conv_cfg_regs.sv
`timescale 1ns/1ps
`include "conv_load_defines.svh"

module conv_cfg_regs (
    input  logic                         clk,
    input  logic                         reset,
    input  logic [`CONV_APB_ADDR_W-1:0]  paddr,
    input  logic                         psel,
    input  logic                         penable,
    input  logic                         pwrite,
    input  logic [31:0]                  pwdata,
    output logic [31:0]                  prdata,
    output logic                         pready,
    output logic                         pslverr,
    input  logic                         busy,
    input  logic                         tile_fin,
    output conv_load_pkg::dim_t          ix,
    output conv_load_pkg::dim_t          iy,
    output conv_load_pkg::dim_t          nif,
    output conv_load_pkg::stride_t       s,
    output logic                         start
);

    localparam logic [`CONV_APB_ADDR_W-1:0] ADDR_CTRL   = 'h00;
    localparam logic [`CONV_APB_ADDR_W-1:0] ADDR_STATUS = 'h04;
    localparam logic [`CONV_APB_ADDR_W-1:0] ADDR_IX     = 'h08;
    localparam logic [`CONV_APB_ADDR_W-1:0] ADDR_IY     = 'h0C;
    localparam logic [`CONV_APB_ADDR_W-1:0] ADDR_NIF    = 'h10;
    localparam logic [`CONV_APB_ADDR_W-1:0] ADDR_STRIDE = 'h14;

    logic        wr_access;
    logic        rd_access;
    logic        locked;
    logic [15:0] tile_cnt;

    assign wr_access = psel && penable && pwrite;
    assign rd_access = psel && penable && !pwrite;

    // start cycle counts as busy too
    assign locked = busy || start;

    // no wait states, no errors
    assign pready  = 1'b1;
    assign pslverr = 1'b0;

    //////////////////////////////
    // register writes
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            ix    <= '0;
            iy    <= '0;
            nif   <= '0;
            s     <= '0;
            start <= 1'b0;
        end else begin
            start <= wr_access && (paddr == ADDR_CTRL) && pwdata[0] && !locked;
            if (wr_access && !locked) begin
                case (paddr)
                    ADDR_IX:     ix  <= pwdata[`CONV_DIM_W-1:0];
                    ADDR_IY:     iy  <= pwdata[`CONV_DIM_W-1:0];
                    ADDR_NIF:    nif <= pwdata[`CONV_DIM_W-1:0];
                    ADDR_STRIDE: s   <= pwdata[3:0];
                    default:     ;
                endcase
            end
        end
    end

    // finished tiles of the current run
    always_ff @(posedge clk) begin
        if (reset) begin
            tile_cnt <= '0;
        end else if (start) begin
            tile_cnt <= '0;
        end else if (tile_fin) begin
            tile_cnt <= tile_cnt + 16'd1;
        end
    end

    //////////////////////////////
    // readback
    //////////////////////////////

    always_comb begin
        prdata = '0;
        if (rd_access) begin
            case (paddr)
                ADDR_STATUS: prdata = {tile_cnt, 15'd0, busy};
                ADDR_IX:     prdata = 32'(ix);
                ADDR_IY:     prdata = 32'(iy);
                ADDR_NIF:    prdata = 32'(nif);
                ADDR_STRIDE: prdata = 32'(s);
                default:     prdata = '0;
            endcase
        end
    end

endmodule

//--- src/load_loop_nest.sv
`timescale 1ns/1ps
`include "conv_load_defines.svh"

module load_loop_nest (
    input  logic                    clk,
    input  logic                    reset,
    input  conv_load_pkg::dim_t     ix,
    input  conv_load_pkg::dim_t     iy,
    input  conv_load_pkg::dim_t     nif,
    input  conv_load_pkg::stride_t  s,
    input  logic                    advance,
    output conv_load_pkg::dim_t     row,
    output conv_load_pkg::dim_t     col_start,
    output conv_load_pkg::dim_t     col_end,
    output conv_load_pkg::dim_t     if_start,
    output conv_load_pkg::dim_t     if_end,
    output conv_load_pkg::bank_t    bank,
    output conv_load_pkg::dim_t     sub_row,
    output conv_load_pkg::dim_t     group_idx,
    output logic                    bank_end,
    output logic                    tile_end,
    output logic                    run_end
);

    localparam conv_load_pkg::dim_t ONE      = conv_load_pkg::dim_t'(1);
    localparam conv_load_pkg::dim_t IF_STEP  = conv_load_pkg::dim_t'(`CONV_IF_GROUP);
    localparam conv_load_pkg::dim_t SEG_STEP = conv_load_pkg::dim_t'(`CONV_SEG_PIXELS);
    localparam conv_load_pkg::dim_t BUFS     = conv_load_pkg::dim_t'(`CONV_BUFFERS_NUM);
    localparam int                  IF_SHIFT = $clog2(`CONV_IF_GROUP);

    // loop counters, all one-based
    conv_load_pkg::dim_t tif;
    conv_load_pkg::dim_t bufy;
    conv_load_pkg::dim_t siy;
    conv_load_pkg::dim_t tix;
    conv_load_pkg::dim_t tiy;

    conv_load_pkg::dim_t s_ext;
    conv_load_pkg::dim_t step_y;
    conv_load_pkg::dim_t siy_m1;
    conv_load_pkg::dim_t if_last;
    conv_load_pkg::dim_t col_last;
    logic                tif_end;
    logic                tix_end;

    //////////////////////////////
    // indices and clipped ranges
    //////////////////////////////

    assign s_ext  = conv_load_pkg::dim_t'(s);
    assign step_y = (s_ext << 1) + s_ext;
    assign siy_m1 = siy - ONE;

    assign row = tiy + (siy_m1 << 1) + siy_m1 + (bufy - ONE);

    assign if_last  = tif + IF_STEP - ONE;
    assign col_last = tix + SEG_STEP - ONE;

    assign col_start = tix;
    assign col_end   = (col_last > ix) ? ix : col_last;
    assign if_start  = tif;
    assign if_end    = (if_last > nif) ? nif : if_last;

    assign bank      = conv_load_pkg::bank_t'(bufy - ONE);
    assign sub_row   = siy;
    assign group_idx = (tif - ONE) >> IF_SHIFT;

    //////////////////////////////
    // loop end events
    //////////////////////////////

    assign tif_end  = advance && (if_last >= nif);
    // last row of the image cuts the bank and sub-row loops short
    assign bank_end = tif_end && ((bufy == BUFS) || (row == iy));
    assign tile_end = bank_end && ((siy == s_ext) || (row == iy));
    assign tix_end  = tile_end && (col_last >= ix);
    assign run_end  = tix_end && ((tiy + step_y > iy) || (row == iy));

    always_ff @(posedge clk) begin
        if (reset) begin
            tif  <= ONE;
            bufy <= ONE;
            siy  <= ONE;
            tix  <= ONE;
            tiy  <= ONE;
        end else if (advance) begin
            tif <= tif_end ? ONE : tif + IF_STEP;
            if (tif_end) begin
                bufy <= bank_end ? ONE : bufy + ONE;
            end
            if (bank_end) begin
                siy <= tile_end ? ONE : siy + ONE;
            end
            if (tile_end) begin
                tix <= tix_end ? ONE : tix + SEG_STEP;
            end
            if (tix_end) begin
                tiy <= run_end ? ONE : tiy + step_y;
            end
        end
    end

endmodule

//--- src/conv_load_controller.sv
`timescale 1ns/1ps
`include "conv_load_defines.svh"

module conv_load_controller (
    input  logic                      clk,
    input  logic                      reset,
    input  conv_load_pkg::dim_t       ix,
    input  conv_load_pkg::dim_t       iy,
    input  conv_load_pkg::dim_t       nif,
    input  conv_load_pkg::stride_t    s,
    input  logic                      start,
    input  logic                      load_continue,
    input  logic                      req_ready,
    output logic                      req_valid,
    output conv_load_pkg::dim_t       req_row,
    output conv_load_pkg::dim_t       req_col_start,
    output conv_load_pkg::dim_t       req_col_end,
    output conv_load_pkg::dim_t       req_if_start,
    output conv_load_pkg::dim_t       req_if_end,
    input  logic                      resp_valid,
    output logic                      wr_en,
    output conv_load_pkg::bank_t      wr_bank,
    output conv_load_pkg::buf_addr_t  wr_addr,
    output logic                      busy,
    output logic                      tile_fin
);

    localparam conv_load_pkg::dim_t ONE      = conv_load_pkg::dim_t'(1);
    localparam conv_load_pkg::dim_t IF_STEP  = conv_load_pkg::dim_t'(`CONV_IF_GROUP);
    localparam int                  IF_SHIFT = $clog2(`CONV_IF_GROUP);

    logic                      run;
    logic                      stall;
    logic                      req_fire;
    logic                      ddr_tile_end;
    logic                      ddr_run_end;
    logic                      buf_bank_end;
    logic                      buf_tile_end;
    logic                      buf_run_end;
    conv_load_pkg::dim_t       buf_group;
    conv_load_pkg::dim_t       group_cnt;
    conv_load_pkg::buf_addr_t  base_addr;

    //////////////////////////////
    // ddr request side
    //////////////////////////////

    assign req_valid = run && !stall;
    assign req_fire  = req_valid && req_ready;

    load_loop_nest u_ddr_nest (
        .clk       (clk),
        .reset     (reset),
        .ix        (ix),
        .iy        (iy),
        .nif       (nif),
        .s         (s),
        .advance   (req_fire),
        .row       (req_row),
        .col_start (req_col_start),
        .col_end   (req_col_end),
        .if_start  (req_if_start),
        .if_end    (req_if_end),
        .bank      (),
        .sub_row   (),
        .group_idx (),
        .bank_end  (),
        .tile_end  (ddr_tile_end),
        .run_end   (ddr_run_end)
    );

    always_ff @(posedge clk) begin
        if (reset) begin
            run   <= 1'b0;
            stall <= 1'b0;
        end else begin
            if (start) begin
                run <= 1'b1;
            end else if (ddr_run_end) begin
                run <= 1'b0;
            end
            // hold requests until the core has drained the buffers
            if (start) begin
                stall <= 1'b0;
            end else if (ddr_tile_end) begin
                stall <= 1'b1;
            end else if (load_continue) begin
                stall <= 1'b0;
            end
        end
    end

    //////////////////////////////
    // buffer write side
    //////////////////////////////

    load_loop_nest u_buf_nest (
        .clk       (clk),
        .reset     (reset),
        .ix        (ix),
        .iy        (iy),
        .nif       (nif),
        .s         (s),
        .advance   (resp_valid),
        .row       (),
        .col_start (),
        .col_end   (),
        .if_start  (),
        .if_end    (),
        .bank      (wr_bank),
        .sub_row   (),
        .group_idx (buf_group),
        .bank_end  (buf_bank_end),
        .tile_end  (buf_tile_end),
        .run_end   (buf_run_end)
    );

    // channel groups per sub-row
    assign group_cnt = (nif + IF_STEP - ONE) >> IF_SHIFT;

    assign wr_en   = resp_valid;
    assign wr_addr = base_addr + conv_load_pkg::buf_addr_t'(buf_group);

    always_ff @(posedge clk) begin
        if (reset) begin
            base_addr <= '0;
            tile_fin  <= 1'b0;
            busy      <= 1'b0;
        end else begin
            if (buf_tile_end) begin
                base_addr <= '0;
            end else if (buf_bank_end) begin
                base_addr <= base_addr + conv_load_pkg::buf_addr_t'(group_cnt);
            end
            tile_fin <= buf_tile_end;
            if (start) begin
                busy <= 1'b1;
            end else if (buf_run_end) begin
                busy <= 1'b0;
            end
        end
    end

endmodule

//--- src/row_buffer_bank.sv
`timescale 1ns/1ps
`include "conv_load_defines.svh"

module row_buffer_bank (
    input  logic                      clk,
    input  logic                      wr_en,
    input  conv_load_pkg::bank_t      wr_bank,
    input  conv_load_pkg::buf_addr_t  wr_addr,
    input  conv_load_pkg::pix_word_t  wr_data,
    input  conv_load_pkg::bank_t      rd_bank,
    input  conv_load_pkg::buf_addr_t  rd_addr,
    output conv_load_pkg::pix_word_t  rd_data
);

    // registered read word of each bank
    conv_load_pkg::pix_word_t bank_q [`CONV_BUFFERS_NUM];
    conv_load_pkg::bank_t     rd_bank_q;

    //////////////////////////////
    // one memory per bank
    //////////////////////////////

    for (genvar b = 0; b < `CONV_BUFFERS_NUM; b++) begin : g_bank
        conv_load_pkg::pix_word_t mem [`CONV_BUF_DEPTH];
        logic                     bank_we;

        assign bank_we = wr_en && (wr_bank == conv_load_pkg::bank_t'(b));

        always_ff @(posedge clk) begin
            if (bank_we) begin
                mem[wr_addr] <= wr_data;
            end
            bank_q[b] <= mem[rd_addr];
        end
    end

    // bank select follows the read data by one cycle
    always_ff @(posedge clk) begin
        rd_bank_q <= rd_bank;
    end

    assign rd_data = bank_q[rd_bank_q];

endmodule

//--- src/conv_input_loader.sv
`timescale 1ns/1ps
`include "conv_load_defines.svh"

module conv_input_loader (
    input  logic                         clk,
    input  logic                         reset,
    // apb config port
    input  logic [`CONV_APB_ADDR_W-1:0]  paddr,
    input  logic                         psel,
    input  logic                         penable,
    input  logic                         pwrite,
    input  logic [31:0]                  pwdata,
    output logic [31:0]                  prdata,
    output logic                         pready,
    output logic                         pslverr,
    // ddr request and response
    output logic                         req_valid,
    input  logic                         req_ready,
    output conv_load_pkg::dim_t          req_row,
    output conv_load_pkg::dim_t          req_col_start,
    output conv_load_pkg::dim_t          req_col_end,
    output conv_load_pkg::dim_t          req_if_start,
    output conv_load_pkg::dim_t          req_if_end,
    input  logic                         resp_valid,
    input  conv_load_pkg::pix_word_t     resp_data,
    // conv core side
    input  logic                         load_continue,
    output logic                         tile_fin,
    input  conv_load_pkg::bank_t         rd_bank,
    input  conv_load_pkg::buf_addr_t     rd_addr,
    output conv_load_pkg::pix_word_t     rd_data
);

    conv_load_pkg::dim_t       ix;
    conv_load_pkg::dim_t       iy;
    conv_load_pkg::dim_t       nif;
    conv_load_pkg::stride_t    s;
    logic                      start;
    logic                      busy;
    logic                      wr_en;
    conv_load_pkg::bank_t      wr_bank;
    conv_load_pkg::buf_addr_t  wr_addr;

    conv_cfg_regs u_regs (
        .clk      (clk),
        .reset    (reset),
        .paddr    (paddr),
        .psel     (psel),
        .penable  (penable),
        .pwrite   (pwrite),
        .pwdata   (pwdata),
        .prdata   (prdata),
        .pready   (pready),
        .pslverr  (pslverr),
        .busy     (busy),
        .tile_fin (tile_fin),
        .ix       (ix),
        .iy       (iy),
        .nif      (nif),
        .s        (s),
        .start    (start)
    );

    conv_load_controller u_ctrl (
        .clk           (clk),
        .reset         (reset),
        .ix            (ix),
        .iy            (iy),
        .nif           (nif),
        .s             (s),
        .start         (start),
        .load_continue (load_continue),
        .req_ready     (req_ready),
        .req_valid     (req_valid),
        .req_row       (req_row),
        .req_col_start (req_col_start),
        .req_col_end   (req_col_end),
        .req_if_start  (req_if_start),
        .req_if_end    (req_if_end),
        .resp_valid    (resp_valid),
        .wr_en         (wr_en),
        .wr_bank       (wr_bank),
        .wr_addr       (wr_addr),
        .busy          (busy),
        .tile_fin      (tile_fin)
    );

    row_buffer_bank u_bufs (
        .clk     (clk),
        .wr_en   (wr_en),
        .wr_bank (wr_bank),
        .wr_addr (wr_addr),
        .wr_data (resp_data),
        .rd_bank (rd_bank),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

endmodule

//--- verification/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk,
    output logic reset
);

    // 20 ns period
    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    initial begin
        reset = 1'b1;
        repeat (4) @(posedge clk);
        reset <= 1'b0;
    end

endmodule

//--- verification/conv_input_loader_tb.sv
`timescale 1ns/1ps
`include "conv_load_defines.svh"

module conv_input_loader_tb;

    logic                            clk;
    logic                            reset;
    logic [`CONV_APB_ADDR_W-1:0]     paddr;
    logic                            psel;
    logic                            penable;
    logic                            pwrite;
    logic [31:0]                     pwdata;
    logic [31:0]                     prdata;
    logic                            pready;
    logic                            pslverr;
    logic                            req_valid;
    logic                            req_ready;
    conv_load_pkg::dim_t             req_row;
    conv_load_pkg::dim_t             req_col_start;
    conv_load_pkg::dim_t             req_col_end;
    conv_load_pkg::dim_t             req_if_start;
    conv_load_pkg::dim_t             req_if_end;
    logic                            resp_valid;
    conv_load_pkg::pix_word_t        resp_data;
    logic                            load_continue;
    logic                            tile_fin;
    conv_load_pkg::bank_t            rd_bank;
    conv_load_pkg::buf_addr_t        rd_addr;
    conv_load_pkg::pix_word_t        rd_data;

    // expected requests and placement
    int ref_row[$];
    int ref_cs[$];
    int ref_ce[$];
    int ref_fs[$];
    int ref_fe[$];
    int ref_bank[$];
    int ref_addr[$];
    int ref_tile_cum[$];

    // observed requests and returned words
    conv_load_pkg::dim_t       obs_row[$];
    conv_load_pkg::dim_t       obs_cs[$];
    conv_load_pkg::dim_t       obs_ce[$];
    conv_load_pkg::dim_t       obs_fs[$];
    conv_load_pkg::dim_t       obs_fe[$];
    conv_load_pkg::pix_word_t  resp_log[$];

    bit rand_ready;
    int err_count;
    int tests_run;
    int tests_failed;
    int wd_cycles;

    tb_clock_gen u_clk (
        .clk   (clk),
        .reset (reset)
    );

    conv_input_loader i_dut (
        .clk           (clk),
        .reset         (reset),
        .paddr         (paddr),
        .psel          (psel),
        .penable       (penable),
        .pwrite        (pwrite),
        .pwdata        (pwdata),
        .prdata        (prdata),
        .pready        (pready),
        .pslverr       (pslverr),
        .req_valid     (req_valid),
        .req_ready     (req_ready),
        .req_row       (req_row),
        .req_col_start (req_col_start),
        .req_col_end   (req_col_end),
        .req_if_start  (req_if_start),
        .req_if_end    (req_if_end),
        .resp_valid    (resp_valid),
        .resp_data     (resp_data),
        .load_continue (load_continue),
        .tile_fin      (tile_fin),
        .rd_bank       (rd_bank),
        .rd_addr       (rd_addr),
        .rd_data       (rd_data)
    );

    //////////////////////////////
    // compare tasks
    //////////////////////////////

    task automatic check_dim(input string what, input conv_load_pkg::dim_t got,
                             input conv_load_pkg::dim_t exp);
        if (got !== exp) begin
            err_count++;
            $display("[ERROR] %0t: %s got %0d expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic check_word(input string what, input conv_load_pkg::pix_word_t got,
                              input conv_load_pkg::pix_word_t exp);
        if (got !== exp) begin
            err_count++;
            $display("[ERROR] %0t: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_bit(input string what, input logic got, input logic exp);
        if (got !== exp) begin
            err_count++;
            $display("[ERROR] %0t: %s got %b expected %b", $time, what, got, exp);
        end
    endtask

    //////////////////////////////
    // apb access
    //////////////////////////////

    task automatic apb_write(input int addr, input int data);
        @(posedge clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= 1'b1;
        paddr   <= `CONV_APB_ADDR_W'(addr);
        pwdata  <= 32'(data);
        @(posedge clk);
        penable <= 1'b1;
        @(posedge clk);
        check_bit("pready on write", pready, 1'b1);
        check_bit("pslverr on write", pslverr, 1'b0);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic apb_read(input int addr, output logic [31:0] data);
        @(posedge clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= 1'b0;
        paddr   <= `CONV_APB_ADDR_W'(addr);
        @(posedge clk);
        penable <= 1'b1;
        @(posedge clk);
        data = prdata;
        check_bit("pready on read", pready, 1'b1);
        check_bit("pslverr on read", pslverr, 1'b0);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    //////////////////////////////
    // reference loop model
    //////////////////////////////

    task automatic build_reference(input int ix, input int iy, input int nif, input int s);
        int tiy;
        int tix;
        int siy;
        int bufy;
        int tif;
        int row;
        int groups;
        bit done;
        ref_row.delete();
        ref_cs.delete();
        ref_ce.delete();
        ref_fs.delete();
        ref_fe.delete();
        ref_bank.delete();
        ref_addr.delete();
        ref_tile_cum.delete();
        groups = (nif + `CONV_IF_GROUP - 1) / `CONV_IF_GROUP;
        tiy = 1;
        done = 1'b0;
        while (!done) begin
            row = 0;
            for (tix = 1; tix <= ix; tix += `CONV_SEG_PIXELS) begin
                for (siy = 1; siy <= s; siy++) begin
                    for (bufy = 1; bufy <= `CONV_BUFFERS_NUM; bufy++) begin
                        row = tiy + 3 * (siy - 1) + (bufy - 1);
                        for (tif = 1; tif <= nif; tif += `CONV_IF_GROUP) begin
                            ref_row.push_back(row);
                            ref_cs.push_back(tix);
                            ref_ce.push_back((tix + `CONV_SEG_PIXELS - 1 > ix) ?
                                             ix : tix + `CONV_SEG_PIXELS - 1);
                            ref_fs.push_back(tif);
                            ref_fe.push_back((tif + `CONV_IF_GROUP - 1 > nif) ?
                                             nif : tif + `CONV_IF_GROUP - 1);
                            ref_bank.push_back(bufy - 1);
                            ref_addr.push_back((siy - 1) * groups
                                               + (tif - 1) / `CONV_IF_GROUP);
                        end
                        if (row == iy) break;
                    end
                    if (row == iy) break;
                end
                ref_tile_cum.push_back(ref_row.size());
            end
            if ((tiy + 3 * s > iy) || (row == iy)) begin
                done = 1'b1;
            end else begin
                tiy += 3 * s;
            end
        end
    endtask

    //////////////////////////////
    // memory responder
    //////////////////////////////

    initial begin
        int pending;
        int delay;
        conv_load_pkg::pix_word_t w;
        pending = 0;
        delay = 0;
        forever begin
            @(posedge clk);
            if (req_valid && req_ready) begin
                obs_row.push_back(req_row);
                obs_cs.push_back(req_col_start);
                obs_ce.push_back(req_col_end);
                obs_fs.push_back(req_if_start);
                obs_fe.push_back(req_if_end);
                pending++;
            end
            if (pending > 0 && delay == 0) begin
                w = {$urandom, $urandom};
                resp_valid <= 1'b1;
                resp_data  <= w;
                resp_log.push_back(w);
                pending--;
                delay = $urandom % 4;
            end else begin
                resp_valid <= 1'b0;
                if (delay > 0) delay--;
            end
        end
    end

    // ready is random under back-pressure
    initial begin
        forever begin
            @(posedge clk);
            req_ready <= rand_ready ? 1'($urandom % 2) : 1'b1;
        end
    end

    //////////////////////////////
    // run one image
    //////////////////////////////

    task automatic check_tile_buffers(input int first, input int last);
        for (int i = first; i < last; i++) begin
            @(posedge clk);
            rd_bank <= conv_load_pkg::bank_t'(ref_bank[i]);
            rd_addr <= conv_load_pkg::buf_addr_t'(ref_addr[i]);
            @(posedge clk);
            @(posedge clk);
            check_word($sformatf("buffer bank %0d addr %0d", ref_bank[i], ref_addr[i]),
                       rd_data, resp_log[i]);
        end
    endtask

    task automatic run_image(input string name, input int ix, input int iy, input int nif,
                             input int s, input bit bp, input bit probe);
        logic [31:0] rd;
        int errs_before;
        int first;
        errs_before = err_count;
        if (probe) begin
            // state straight out of reset
            check_bit("req_valid after reset", req_valid, 1'b0);
            check_bit("tile_fin after reset", tile_fin, 1'b0);
            apb_read('h04, rd);
            check_dim("STATUS after reset", rd[15:0], 16'd0);
            check_dim("STATUS count after reset", rd[31:16], 16'd0);
        end
        build_reference(ix, iy, nif, s);
        obs_row.delete();
        obs_cs.delete();
        obs_ce.delete();
        obs_fs.delete();
        obs_fe.delete();
        resp_log.delete();
        rand_ready = bp;
        apb_write('h08, ix);
        apb_write('h0C, iy);
        apb_write('h10, nif);
        apb_write('h14, s);
        if (probe) begin
            apb_read('h08, rd);
            check_dim("IX readback", rd[15:0], 16'(ix));
            apb_read('h0C, rd);
            check_dim("IY readback", rd[15:0], 16'(iy));
            apb_read('h10, rd);
            check_dim("NIF readback", rd[15:0], 16'(nif));
            apb_read('h14, rd);
            check_dim("STRIDE readback", rd[15:0], 16'(s));
        end
        apb_write('h00, 1);
        if (probe) begin
            // locked while busy
            apb_write('h08, ix + 77);
            apb_read('h08, rd);
            check_dim("IX after write while busy", rd[15:0], 16'(ix));
        end
        first = 0;
        for (int k = 0; k < ref_tile_cum.size(); k++) begin
            @(posedge clk);
            while (!tile_fin) @(posedge clk);
            repeat (4) begin
                @(posedge clk);
                check_bit("req_valid during tile stall", req_valid, 1'b0);
            end
            check_tile_buffers(first, ref_tile_cum[k]);
            // nothing may have gone out while the core reads the buffers
            check_dim("requests issued by tile end", 16'(obs_row.size()),
                      16'(ref_tile_cum[k]));
            first = ref_tile_cum[k];
            @(posedge clk);
            load_continue <= 1'b1;
            @(posedge clk);
            load_continue <= 1'b0;
            if (k < ref_tile_cum.size() - 1) begin
                @(posedge clk);
                check_bit("req_valid after load_continue", req_valid, 1'b1);
            end
        end
        rd = 32'h1;
        while (rd[0]) apb_read('h04, rd);
        check_dim("STATUS tile count", rd[31:16], 16'(ref_tile_cum.size()));
        repeat (4) begin
            @(posedge clk);
            check_bit("req_valid after run", req_valid, 1'b0);
        end
        check_dim("request count", 16'(obs_row.size()), 16'(ref_row.size()));
        for (int i = 0; i < ref_row.size() && i < obs_row.size(); i++) begin
            check_dim($sformatf("req %0d row", i), obs_row[i], 16'(ref_row[i]));
            check_dim($sformatf("req %0d col_start", i), obs_cs[i], 16'(ref_cs[i]));
            check_dim($sformatf("req %0d col_end", i), obs_ce[i], 16'(ref_ce[i]));
            check_dim($sformatf("req %0d if_start", i), obs_fs[i], 16'(ref_fs[i]));
            check_dim($sformatf("req %0d if_end", i), obs_fe[i], 16'(ref_fe[i]));
        end
        rand_ready = 1'b0;
        tests_run++;
        if (err_count == errs_before) begin
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: failed with %0d errors", name, err_count - errs_before);
        end
    endtask

    //////////////////////////////
    // watchdog
    //////////////////////////////

    initial begin
        wait (wd_cycles > 0);
        repeat (wd_cycles) @(posedge clk);
        $display("timeout: run did not finish within %0d cycles", wd_cycles);
        $display(">>> FAIL");
        $finish;
    end

    //////////////////////////////
    // main sequence
    //////////////////////////////

    initial begin
        int total;
        paddr         = '0;
        psel          = 1'b0;
        penable       = 1'b0;
        pwrite        = 1'b0;
        pwdata        = '0;
        req_ready     = 1'b1;
        resp_valid    = 1'b0;
        resp_data     = '0;
        load_continue = 1'b0;
        rd_bank       = '0;
        rd_addr       = '0;
        rand_ready    = 1'b0;
        err_count     = 0;
        tests_run     = 0;
        tests_failed  = 0;
        wd_cycles     = 0;
        void'($urandom(32'h4fd6_9a47));

        // watchdog budget from all runs
        total = 0;
        build_reference(20, 3, 4, 1);
        total += 3 * ref_row.size();
        build_reference(40, 7, 5, 2);
        total += ref_row.size();
        build_reference(70, 10, 3, 1);
        total += ref_row.size();
        build_reference(32, 9, 6, 3);
        total += ref_row.size();
        wd_cycles = 50 * total + 2000;

        @(posedge clk);
        while (reset) @(posedge clk);

        run_image("reset and registers", 20, 3, 4, 1, 1'b0, 1'b1);
        run_image("request order", 20, 3, 4, 1, 1'b0, 1'b0);
        run_image("back-pressure", 20, 3, 4, 1, 1'b1, 1'b0);
        run_image("clipping", 40, 7, 5, 2, 1'b1, 1'b0);
        run_image("tile stall", 70, 10, 3, 1, 1'b0, 1'b0);
        run_image("buffer contents", 32, 9, 6, 3, 1'b1, 1'b0);

        $display("tests run: %0d, failed: %0d, errors: %0d",
                 tests_run, tests_failed, err_count);
        if (err_count == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

//--- build.f
+incdir+include
src/conv_load_pkg.sv
src/conv_cfg_regs.sv
src/load_loop_nest.sv
src/conv_load_controller.sv
src/row_buffer_bank.sv
src/conv_input_loader.sv
verification/tb_clock_gen.sv
verification/conv_input_loader_tb.sv

//--- run_sim.sh
#!/bin/sh
# Compile and run the testbench with Verilator from the project root.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -f build.f --top-module conv_input_loader_tb \
    -Mdir obj_dir -o conv_input_loader_sim
if [ $? -ne 0 ]; then
    echo "compile failed"
    exit 1
fi

./obj_dir/conv_input_loader_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q ">>> FAIL" "$LOG"; then
    exit 1
fi
exit 0
